// File: src/soc_pkg.sv
//////////////////////////////////////////////////////////////////////
// Address map, reset length, opcode and state enums, bus structs
//////////////////////////////////////////////////////////////////////
`default_nettype none

package soc_pkg;

	// Post-reset hold-off before the bus opens
	localparam int unsigned RESET_CYCLES = 256;
	localparam int unsigned RST_CNT_W = $clog2(RESET_CYCLES);
	localparam logic [RST_CNT_W-1:0] RST_CNT_MAX = RST_CNT_W'(RESET_CYCLES - 1);

	// Memory geometry
	localparam int unsigned ROM_AW = 12;
	localparam int unsigned RAM_AW = 12;
	localparam int unsigned FB_AW = 14;

	localparam string ROM_IMAGE = "boot_rom.hex";

	// Access opcode seen on the request port
	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} bus_op_e;

	// Controller states
	typedef enum logic [1:0] {
		st_idle    = 2'd0,
		st_access  = 2'd1,
		st_respond = 2'd2
	} ctrl_state_e;

	// Processor request, 25 bits
	typedef struct packed {
		bus_op_e     op;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} bus_req_t;

	// Response, rdata is zero for writes
	typedef struct packed {
		logic [7:0] rdata;
	} bus_rsp_t;

	// Shared command to all three memories, 23 bits
	typedef struct packed {
		logic [FB_AW-1:0] addr;
		logic [7:0]       wdata;
		logic             we;
	} mem_cmd_t;

endpackage

`default_nettype wire

// File: src/reset_timer.sv
//////////////////////////////////////////////////////////////////////
// Post-reset hold-off counter that opens the bus
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module reset_timer (
	input  logic cpu_clock,
	input  logic rst,
	output logic bus_open
);
	import soc_pkg::*;

	logic [RST_CNT_W-1:0] cnt;

	// Saturating count, stops at the limit
	always_ff @(posedge cpu_clock) begin
		if (rst) begin
			cnt <= '0;
		end else if (cnt != RST_CNT_MAX) begin
			cnt <= cnt + 1'b1;
		end
	end

	// One extra register stage so the bus opens on the full count
	always_ff @(posedge cpu_clock) begin
		if (rst) begin
			bus_open <= 1'b0;
		end else begin
			bus_open <= (cnt == RST_CNT_MAX);
		end
	end

	// Once saturated the count holds until the next reset
	a_cnt_sat: assert property (@(posedge cpu_clock) disable iff (rst)
		cnt == RST_CNT_MAX |=> cnt == RST_CNT_MAX);

	// Bus never opens before the limit was reached
	a_open_late: assert property (@(posedge cpu_clock) disable iff (rst)
		bus_open |-> cnt == RST_CNT_MAX);

endmodule

`default_nettype wire

// File: src/bus_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Access FSM: decode, memory command, response register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module bus_ctrl (
	input  logic              cpu_clock,
	input  logic              rst,
	input  logic              bus_open,
	input  logic              req_valid,
	input  soc_pkg::bus_req_t req,
	output logic              req_ready,
	output logic              rsp_valid,
	output soc_pkg::bus_rsp_t rsp,
	input  logic              rsp_ready,
	output soc_pkg::mem_cmd_t cmd,
	output logic              ram_we,
	output logic              fb_we,
	input  logic [7:0]        rom_q,
	input  logic [7:0]        ram_q
);
	import soc_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_next;
	logic        upper_half;
	logic        req_fire;
	logic        rsp_fire;
	logic [7:0]  rd_sel;

	// Only one access in flight, so accept only when idle
	assign req_ready = (state == st_idle) && bus_open;
	assign req_fire = req_valid && req_ready;
	assign rsp_fire = rsp_valid && rsp_ready;

	// Write strobes last exactly the st_access cycle
	assign ram_we = (state == st_access) && cmd.we && upper_half;
	assign fb_we = (state == st_access) && cmd.we && !upper_half;

	// Read source by half, writes answer zero
	assign rd_sel = cmd.we ? 8'h00 : (upper_half ? ram_q : rom_q);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (req_fire) begin
					state_next = st_access;
				end
			end
			st_access: begin
				state_next = st_respond;
			end
			st_respond: begin
				if (rsp_fire) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge cpu_clock) begin
		if (rst) begin
			state <= st_idle;
			rsp_valid <= 1'b0;
		end else begin
			state <= state_next;
			// First st_respond cycle loads the response
			if (rsp_fire) begin
				rsp_valid <= 1'b0;
			end else if (state == st_respond) begin
				rsp_valid <= 1'b1;
			end
		end
	end

	// Request capture and response data
	always_ff @(posedge cpu_clock) begin
		if (req_fire) begin
			cmd.addr <= req.addr[FB_AW-1:0];
			cmd.wdata <= req.wdata;
			cmd.we <= (req.op == op_write);
			upper_half <= req.addr[15];
		end
		if ((state == st_respond) && !rsp_valid) begin
			rsp.rdata <= rd_sel;
		end
	end

	a_rsp_hold: assert property (@(posedge cpu_clock) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

	a_one_strobe: assert property (@(posedge cpu_clock) disable iff (rst)
		!(ram_we && fb_we));

endmodule

`default_nettype wire

// File: src/boot_rom.sv
//////////////////////////////////////////////////////////////////////
// Boot ROM with registered output, loaded from the boot image
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module boot_rom (
	input  logic                       cpu_clock,
	input  logic [soc_pkg::ROM_AW-1:0] addr,
	output logic [7:0]                 q
);
	import soc_pkg::*;

	logic [7:0] mem [0:(2**ROM_AW)-1];

	// Image is shorter than the ROM, the remainder stays zero
	initial begin
		for (int i = 0; i < 2**ROM_AW; i++) begin
			mem[i] = 8'h00;
		end
		$readmemh(ROM_IMAGE, mem);
	end

	always_ff @(posedge cpu_clock) begin
		q <= mem[addr];
	end

endmodule

`default_nettype wire

// File: src/ram4k.sv
//////////////////////////////////////////////////////////////////////
// 4 KiB single-port RAM, read-before-write
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ram4k (
	input  logic                       cpu_clock,
	input  logic [soc_pkg::RAM_AW-1:0] addr,
	input  logic [7:0]                 wdata,
	input  logic                       we,
	output logic [7:0]                 q
);
	import soc_pkg::*;

	logic [7:0] mem [0:(2**RAM_AW)-1];

	always_ff @(posedge cpu_clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Old contents come out on a write cycle
	always_ff @(posedge cpu_clock) begin
		q <= mem[addr];
	end

endmodule

`default_nettype wire

// File: src/frame_buffer.sv
//////////////////////////////////////////////////////////////////////
// 16 KiB video memory, processor write port and video read port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module frame_buffer (
	input  logic                      cpu_clock,
	input  logic [soc_pkg::FB_AW-1:0] addr,
	input  logic [7:0]                wdata,
	input  logic                      we,
	input  logic [soc_pkg::FB_AW-1:0] vid_addr,
	output logic [7:0]                vid_data
);
	import soc_pkg::*;

	logic [7:0] mem [0:(2**FB_AW)-1];

	// Blank screen at start
	initial begin
		for (int i = 0; i < 2**FB_AW; i++) begin
			mem[i] = 8'h00;
		end
	end

	// Processor side writes only
	always_ff @(posedge cpu_clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Video side reads only, one cycle behind vid_addr
	always_ff @(posedge cpu_clock) begin
		vid_data <= mem[vid_addr];
	end

endmodule

`default_nettype wire

// File: src/soc.sv
//////////////////////////////////////////////////////////////////////
// Top level: reset timer, bus controller, ROM, RAM, frame buffer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module soc (
	input  logic                      cpu_clock,
	input  logic                      rst,
	input  logic                      req_valid,
	input  soc_pkg::bus_req_t         req,
	output logic                      req_ready,
	output logic                      rsp_valid,
	output soc_pkg::bus_rsp_t         rsp,
	input  logic                      rsp_ready,
	input  logic [soc_pkg::FB_AW-1:0] vid_addr,
	output logic [7:0]                vid_data
);
	import soc_pkg::*;

	logic       bus_open;
	mem_cmd_t   cmd;
	logic       ram_we;
	logic       fb_we;
	logic [7:0] rom_q;
	logic [7:0] ram_q;

	reset_timer reset_timer_i (
		.cpu_clock (cpu_clock),
		.rst       (rst),
		.bus_open  (bus_open)
	);

	bus_ctrl bus_ctrl_i (
		.cpu_clock (cpu_clock),
		.rst       (rst),
		.bus_open  (bus_open),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.rsp_ready (rsp_ready),
		.cmd       (cmd),
		.ram_we    (ram_we),
		.fb_we     (fb_we),
		.rom_q     (rom_q),
		.ram_q     (ram_q)
	);

	// Each memory takes the low address bits it needs
	boot_rom boot_rom_i (
		.cpu_clock (cpu_clock),
		.addr      (cmd.addr[ROM_AW-1:0]),
		.q         (rom_q)
	);

	ram4k ram4k_i (
		.cpu_clock (cpu_clock),
		.addr      (cmd.addr[RAM_AW-1:0]),
		.wdata     (cmd.wdata),
		.we        (ram_we),
		.q         (ram_q)
	);

	frame_buffer frame_buffer_i (
		.cpu_clock (cpu_clock),
		.addr      (cmd.addr),
		.wdata     (cmd.wdata),
		.we        (fb_we),
		.vid_addr  (vid_addr),
		.vid_data  (vid_data)
	);

endmodule

`default_nettype wire

// File: dv/soc_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for soc: LFSR stimulus, reference model, compare, watchdog
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module soc_tb;
	import soc_pkg::*;

	localparam int N_ACC = 300;
	localparam int N_VID_RAND = 64;
	localparam int WATCHDOG_NS = (RESET_CYCLES + 8 + 20 * N_ACC) * 4;

	logic              cpu_clock = 1'b0;
	logic              rst = 1'b1;
	logic              req_valid = 1'b0;
	bus_req_t          req = '0;
	logic              req_ready;
	logic              rsp_valid;
	bus_rsp_t          rsp;
	logic              rsp_ready = 1'b0;
	logic [FB_AW-1:0]  vid_addr = '0;
	logic [7:0]        vid_data;

	// Stimulus and rsp_ready each run their own LFSR
	logic [15:0] stim_lfsr = 16'd38310;
	logic [15:0] ready_lfsr = 16'd38310;

	// Reference memories
	logic [7:0]       rom_model [0:(2**ROM_AW)-1];
	logic [7:0]       ram_model [0:(2**RAM_AW)-1];
	logic             ram_known [0:(2**RAM_AW)-1];
	logic [7:0]       fb_model [0:(2**FB_AW)-1];
	logic [FB_AW-1:0] fb_written [$];

	// Expected responses, bit 8 marks a predictable value
	logic [8:0] exp_q [$];

	int rsp_errs = 0;
	int proto_errs = 0;
	int hold_errs = 0;
	int video_errs = 0;
	int skipped = 0;
	int rsp_cnt = 0;
	int cyc = 0;
	int acc_cyc = 0;

	soc dut_i (
		.cpu_clock (cpu_clock),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.rsp_ready (rsp_ready),
		.vid_addr  (vid_addr),
		.vid_data  (vid_data)
	);

	always #2 cpu_clock = ~cpu_clock;

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	function automatic logic [15:0] draw_bits(int unsigned n);
		logic [15:0] v;
		v = '0;
		for (int unsigned i = 0; i < n; i++) begin
			v = {v[14:0], stim_lfsr[0]};
			stim_lfsr = lfsr_step(stim_lfsr);
		end
		return v;
	endfunction

	// Half of the offsets land in the first 32 bytes so RAM reads hit earlier writes
	function automatic bus_req_t make_req();
		bus_req_t    r;
		logic [15:0] v;
		v = draw_bits(1);
		r.op = v[0] ? op_write : op_read;
		v = draw_bits(1);
		r.addr[15] = v[0];
		r.addr[14:12] = 3'(draw_bits(3));
		v = draw_bits(1);
		if (v[0]) begin
			r.addr[11:0] = 12'(draw_bits(5));
		end else begin
			r.addr[11:0] = 12'(draw_bits(12));
		end
		r.wdata = 8'(draw_bits(8));
		return r;
	endfunction

	// Address map rule: reads split ROM and RAM, writes split frame buffer and RAM
	function automatic logic [8:0] ref_access(bus_req_t r);
		logic [8:0] res;
		res = {1'b1, 8'h00};
		if (r.op == op_write) begin
			if (r.addr[15]) begin
				ram_model[r.addr[11:0]] = r.wdata;
				ram_known[r.addr[11:0]] = 1'b1;
			end else begin
				fb_model[r.addr[13:0]] = r.wdata;
				fb_written.push_back(r.addr[13:0]);
			end
		end else if (r.addr[15]) begin
			res = {ram_known[r.addr[11:0]], ram_model[r.addr[11:0]]};
		end else begin
			res = {1'b1, rom_model[r.addr[11:0]]};
		end
		return res;
	endfunction

	task automatic check_pixel(input logic [FB_AW-1:0] a);
		vid_addr <= a;
		@(posedge cpu_clock);
		@(negedge cpu_clock);
		assert (vid_data === fb_model[a]) else begin
			$display("ERR %0t: vid_data %h at pixel %h, expected %h",
				$time, vid_data, a, fb_model[a]);
			video_errs++;
		end
		@(posedge cpu_clock);
	endtask

	// Free-running back-pressure
	always @(posedge cpu_clock) begin
		rsp_ready <= ready_lfsr[0];
		ready_lfsr <= lfsr_step(ready_lfsr);
	end

	// Handshake monitor, sampled at the edge before any update lands
	always @(posedge cpu_clock) begin : compare
		logic [8:0] exp;
		logic       rsp_valid_q;
		logic       hold_chk;
		bus_rsp_t   held;
		cyc++;
		if (rst) begin
			rsp_valid_q = 1'b0;
			hold_chk = 1'b0;
		end else begin
			// A first high sample means rsp_valid rose on the previous edge
			if (rsp_valid && !rsp_valid_q) begin
				assert (cyc - 1 - acc_cyc == 2) else begin
					$display("ERR %0t: rsp_valid rose %0d edges after accept",
						$time, cyc - 1 - acc_cyc);
					proto_errs++;
				end
			end
			if (hold_chk) begin
				assert (rsp_valid && rsp === held) else begin
					$display("ERR %0t: response changed while waiting, %h then %h",
						$time, held, rsp);
					proto_errs++;
				end
			end
			hold_chk = rsp_valid && !rsp_ready;
			held = rsp;
			if (rsp_valid && rsp_ready) begin
				assert (exp_q.size() != 0) else begin
					$display("Response transferred with no request outstanding");
					proto_errs++;
				end
				if (exp_q.size() != 0) begin
					exp = exp_q.pop_front();
					if (!exp[8]) begin
						skipped++;
					end else begin
						assert (rsp.rdata === exp[7:0]) else begin
							$display("ERR %0t: rdata %h, expected %h",
								$time, rsp.rdata, exp[7:0]);
							rsp_errs++;
						end
					end
				end
				rsp_cnt++;
			end
			if (req_valid && req_ready) begin
				assert (exp_q.size() == 0 && !rsp_valid) else begin
					$display("ERR %0t: request accepted while a response is pending", $time);
					proto_errs++;
				end
				exp_q.push_back(ref_access(req));
				acc_cyc = cyc;
			end
			rsp_valid_q = rsp_valid;
		end
	end

	initial begin
		int unsigned n_fb;
		for (int i = 0; i < 2**ROM_AW; i++) begin
			rom_model[i] = 8'h00;
			ram_model[i] = 8'h00;
			ram_known[i] = 1'b0;
		end
		for (int i = 0; i < 2**FB_AW; i++) begin
			fb_model[i] = 8'h00;
		end
		$readmemh(ROM_IMAGE, rom_model);

		repeat (8) @(posedge cpu_clock);
		rst <= 1'b0;

		// Bus stays closed for the hold-off, then opens
		for (int i = 1; i <= RESET_CYCLES; i++) begin
			@(posedge cpu_clock);
			assert (!req_ready && !rsp_valid) else begin
				$display("ERR %0t: bus active %0d cycles after reset", $time, i);
				hold_errs++;
			end
		end
		@(posedge cpu_clock);
		assert (req_ready) else begin
			$display("ERR %0t: req_ready still low after the hold-off", $time);
			hold_errs++;
		end

		for (int n = 0; n < N_ACC; n++) begin
			int unsigned gap;
			gap = draw_bits(2);
			if (gap != 0) begin
				req_valid <= 1'b0;
				repeat (gap) @(posedge cpu_clock);
			end
			req <= make_req();
			req_valid <= 1'b1;
			@(posedge cpu_clock);
			while (!req_ready) begin
				@(posedge cpu_clock);
			end
		end
		req_valid <= 1'b0;
		while (rsp_cnt < N_ACC) begin
			@(posedge cpu_clock);
		end
		assert (exp_q.size() == 0) else begin
			$display("Responses still outstanding after the last transfer");
			proto_errs++;
		end

		// Written pixels first, then random ones that are mostly blank
		n_fb = fb_written.size();
		for (int unsigned i = 0; i < n_fb; i++) begin
			check_pixel(fb_written[i]);
		end
		for (int i = 0; i < N_VID_RAND; i++) begin
			check_pixel(FB_AW'(draw_bits(FB_AW)));
		end

		$display("errors: rsp %0d, protocol %0d, hold-off %0d, video %0d (unpredictable reads %0d)",
			rsp_errs, proto_errs, hold_errs, video_errs, skipped);
		if (rsp_errs + proto_errs + hold_errs + video_errs == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all accesses completed");
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: boot_rom.hex
// One byte per line in hex, boot ROM address 0x000 upward
a9
00
8d
00
80
a2
10
bd
00
80
9d
00
00
ca
d0
f7
a9
3f
8d
01
80
4c
15
00
ea
ea
58
60
00
ff
c3
5a

// File: list.f
src/soc_pkg.sv
src/reset_timer.sv
src/bus_ctrl.sv
src/boot_rom.sv
src/ram4k.sv
src/frame_buffer.sv
src/soc.sv
dv/soc_tb.sv

// File: Bender.yml
package:
  name: soc

sources:
  - src/soc_pkg.sv
  - src/reset_timer.sv
  - src/bus_ctrl.sv
  - src/boot_rom.sv
  - src/ram4k.sv
  - src/frame_buffer.sv
  - src/soc.sv
  - target: test
    files:
      - dv/soc_tb.sv
